// ==== audio_config.svh ====
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// microphone clock runs at clk_m / 32
`define MIC_CLK_DIV 32

// mic ticks summed into one tally sample
`define PDM_WINDOW 256

// signed tally and tone sample width
`define PCM_W 8

// signed decimator sample width
`define DEC_W 16

// cascaded halving FIR stages
`define DEC_STAGES 2

`endif

// ==== audio_pkg.sv ====
`include "audio_config.svh"

package audio_pkg;

  // tally or tone sample with its one-cycle strobe
  typedef struct packed {
    logic                     valid;
    logic signed [`PCM_W-1:0] data;
  } pcm_t;

  // decimator sample, wide enough for the filter output
  typedef struct packed {
    logic                     valid;
    logic signed [`DEC_W-1:0] data;
  } dec_t;

  typedef enum logic [1:0] {
    SRC_TONE   = 2'd0,  // stepped sine
    SRC_DEC    = 2'd1,  // decimated mic
    SRC_MIC    = 2'd2,  // raw pdm bit straight to speaker
    SRC_SILENT = 2'd3
  } src_sel_e;

  // one full period, round(127 * sin(2*pi*k/64))
  localparam logic signed [7:0] SINE_TABLE [64] = '{
       8'sd0,   8'sd12,   8'sd25,   8'sd37,   8'sd49,   8'sd60,   8'sd71,   8'sd81,
      8'sd90,   8'sd98,  8'sd106,  8'sd112,  8'sd117,  8'sd122,  8'sd125,  8'sd126,
     8'sd127,  8'sd126,  8'sd125,  8'sd122,  8'sd117,  8'sd112,  8'sd106,   8'sd98,
      8'sd90,   8'sd81,   8'sd71,   8'sd60,   8'sd49,   8'sd37,   8'sd25,   8'sd12,
       8'sd0,  -8'sd12,  -8'sd25,  -8'sd37,  -8'sd49,  -8'sd60,  -8'sd71,  -8'sd81,
     -8'sd90,  -8'sd98, -8'sd106, -8'sd112, -8'sd117, -8'sd122, -8'sd125, -8'sd126,
    -8'sd127, -8'sd126, -8'sd125, -8'sd122, -8'sd117, -8'sd112, -8'sd106,  -8'sd98,
     -8'sd90,  -8'sd81,  -8'sd71,  -8'sd60,  -8'sd49,  -8'sd37,  -8'sd25,  -8'sd12
  };

endpackage

// ==== mic_clock_gen.sv ====
`include "audio_config.svh"

module mic_clock_gen (
  input  logic clk_m,
  input  logic rst_n,
  output logic mic_clk,
  output logic pdm_tick
);

  logic [$clog2(`MIC_CLK_DIV)-1:0] div_cnt;  // position within one mic clock period

  always_ff @(posedge clk_m) begin
    if (!rst_n) begin
      div_cnt  <= '0;
      mic_clk  <= 1'b0;
      pdm_tick <= 1'b0;
    end else begin
      if (div_cnt == `MIC_CLK_DIV - 1) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      // high for the 16 cycles following a count of 0
      mic_clk  <= (div_cnt < `MIC_CLK_DIV / 2);
      // one strobe, aligned with the first high cycle of mic_clk
      pdm_tick <= (div_cnt == '0);
    end
  end

endmodule

// ==== pdm_tally.sv ====
`include "audio_config.svh"

module pdm_tally import audio_pkg::*; (
  input  logic clk_m,
  input  logic rst_n,
  input  logic pdm_tick,
  input  logic mic_data,
  output pcm_t pcm
);

  logic [$clog2(`PDM_WINDOW)-1:0] tick_cnt;  // ticks already taken in this window
  logic [$clog2(`PDM_WINDOW):0]   ones_cnt;  // 9 bits so a full window of ones fits
  logic [$clog2(`PDM_WINDOW):0]   ones_total;
  logic signed [9:0]              centered;
  logic signed [`PCM_W-1:0]       sat_data;

  always_comb begin
    ones_total = ones_cnt + {8'd0, mic_data};      // count including the current bit
    centered   = signed'({1'b0, ones_total}) - 10'sd128;
    // only the top end can overflow, 256 ones gives 128
    sat_data   = (centered > 10'sd127) ? 8'sd127 : centered[`PCM_W-1:0];
  end

  always_ff @(posedge clk_m) begin
    if (!rst_n) begin
      tick_cnt  <= '0;
      ones_cnt  <= '0;
      pcm.valid <= 1'b0;
    end else begin
      pcm.valid <= 1'b0;
      if (pdm_tick) begin
        if (tick_cnt == `PDM_WINDOW - 1) begin
          // last capture of the window
          pcm.valid <= 1'b1;
          pcm.data  <= sat_data;
          tick_cnt  <= '0;
          ones_cnt  <= '0;
        end else begin
          tick_cnt <= tick_cnt + 1'b1;
          ones_cnt <= ones_total;
        end
      end
    end
  end

endmodule

// ==== fir_decimator.sv ====
`include "audio_config.svh"

module fir_decimator import audio_pkg::*; (
  input  logic clk_m,
  input  logic rst_n,
  input  dec_t sample_in,
  output dec_t sample_out
);

  // four tap window, x0 is the sample arriving now
  logic signed [`DEC_W-1:0] x0;
  logic signed [`DEC_W-1:0] x1;
  logic signed [`DEC_W-1:0] x2;
  logic signed [`DEC_W-1:0] x3;

  // taps widened by 3 bits so the 1-3-3-1 sum can't overflow
  logic signed [`DEC_W+2:0] w0;
  logic signed [`DEC_W+2:0] w1;
  logic signed [`DEC_W+2:0] w2;
  logic signed [`DEC_W+2:0] w3;
  logic signed [`DEC_W+2:0] acc;

  logic phase;  // set after an odd number of accepted samples

  assign x0 = sample_in.data;

  // signed to signed assignments sign-extend
  assign w0 = x0;
  assign w1 = x1;
  assign w2 = x2;
  assign w3 = x3;

  always_comb begin
    acc = w0;
    acc = acc + (w1 <<< 1) + w1;  // 3 * x1
    acc = acc + (w2 <<< 1) + w2;  // 3 * x2
    acc = acc + w3;
  end

  always_ff @(posedge clk_m) begin
    if (!rst_n) begin
      x1         <= '0;
      x2         <= '0;
      x3         <= '0;
      phase      <= 1'b0;
      sample_out <= '0;
    end else begin
      sample_out.valid <= 1'b0;
      if (sample_in.valid) begin
        // shift history, newest first
        x1    <= x0;
        x2    <= x1;
        x3    <= x2;
        phase <= ~phase;
        if (phase) begin
          // every second input produces a sample
          sample_out.valid <= 1'b1;
          // dropping the low 3 bits divides by the tap sum of 8
          sample_out.data  <= acc[`DEC_W+2:3];
        end
      end
    end
  end

endmodule

// ==== sine_tone_gen.sv ====
module sine_tone_gen import audio_pkg::*; (
  input  logic clk_m,
  input  logic rst_n,
  input  pcm_t step,
  output pcm_t tone
);

  // 64 steps per period, tone pitch follows the tally rate
  logic [5:0] phase_idx;

  always_ff @(posedge clk_m) begin
    if (!rst_n) begin
      phase_idx  <= '0;
      tone.valid <= 1'b0;
    end else begin
      tone.valid <= step.valid;
      if (step.valid) begin
        tone.data <= SINE_TABLE[phase_idx];
        phase_idx <= phase_idx + 1'b1;  // wraps at 64
      end
    end
  end

endmodule

// ==== audio_output_stage.sv ====
`include "audio_config.svh"

module audio_output_stage import audio_pkg::*; (
  input  logic     clk_m,
  input  logic     rst_n,
  input  logic     pdm_tick,
  input  src_sel_e src_sel,
  input  logic [2:0] vol,
  input  pcm_t     tone,
  input  dec_t     dec,
  input  logic     mic_data,
  output logic     spk
);

  logic signed [`PCM_W-1:0] tone_hold;  // last tone entry
  logic signed [`PCM_W-1:0] dec_hold;   // last decimated sample, clipped
  logic signed [`PCM_W-1:0] dec_sat;
  logic signed [`PCM_W-1:0] src_val;
  logic signed [`PCM_W-1:0] level;      // volume-scaled source
  logic [`PCM_W-1:0]        level_off;  // level + 128 as unsigned
  logic [`PCM_W-1:0]        sd_acc;     // modulator error accumulator
  logic [`PCM_W:0]          sd_sum;     // msb is the carry out

  always_comb begin
    if (dec.data > 16'sd127) begin
      dec_sat = 8'sd127;
    end else if (dec.data < -16'sd128) begin
      dec_sat = -8'sd128;
    end else begin
      dec_sat = dec.data[`PCM_W-1:0];
    end
    unique case (src_sel)
      SRC_TONE: src_val = tone_hold;
      SRC_DEC:  src_val = dec_hold;
      default:  src_val = '0;  // mic bypasses the modulator, silent is mid scale
    endcase
    level_off = {~level[`PCM_W-1], level[`PCM_W-2:0]};  // flip sign bit for offset binary
    sd_sum    = {1'b0, sd_acc} + {1'b0, level_off};
  end

  always_ff @(posedge clk_m) begin
    if (!rst_n) begin
      tone_hold <= '0;
      dec_hold  <= '0;
      level     <= '0;
      sd_acc    <= '0;
      spk       <= 1'b0;
    end else begin
      if (tone.valid) tone_hold <= tone.data;
      if (dec.valid)  dec_hold  <= dec_sat;
      level <= src_val >>> (3'd7 - vol);  // vol 7 is full scale
      if (pdm_tick) begin
        sd_acc <= sd_sum[`PCM_W-1:0];
        // raw mic mode passes the bit captured on this tick
        spk    <= (src_sel == SRC_MIC) ? mic_data : sd_sum[`PCM_W];
      end
    end
  end

endmodule

// ==== audio_top.sv ====
`include "audio_config.svh"

module audio_top import audio_pkg::*; (
  input  logic       clk_m,
  input  logic       rst_n,
  input  logic       mic_data,
  input  src_sel_e   src_sel,
  input  logic [2:0] vol,
  output logic       mic_clk,
  output logic       spk,
  output dec_t       dec_out
);

  logic pdm_tick;  // one cycle per mic clock period
  pcm_t pcm;       // tally samples
  pcm_t tone;

  // entry 0 is the widened tally, entry i+1 the output of stage i
  dec_t dec_chain [`DEC_STAGES+1];

  mic_clock_gen u_mic_clock_gen (
    .clk_m    (clk_m),
    .rst_n    (rst_n),
    .mic_clk  (mic_clk),
    .pdm_tick (pdm_tick)
  );

  pdm_tally u_pdm_tally (
    .clk_m    (clk_m),
    .rst_n    (rst_n),
    .pdm_tick (pdm_tick),
    .mic_data (mic_data),
    .pcm      (pcm)
  );

  assign dec_chain[0].valid = pcm.valid;
  assign dec_chain[0].data  = {{(`DEC_W-`PCM_W){pcm.data[`PCM_W-1]}}, pcm.data};  // sign extend

  for (genvar i = 0; i < `DEC_STAGES; i++) begin : g_dec
    fir_decimator u_fir_decimator (
      .clk_m      (clk_m),
      .rst_n      (rst_n),
      .sample_in  (dec_chain[i]),
      .sample_out (dec_chain[i+1])
    );
  end

  assign dec_out = dec_chain[`DEC_STAGES];

  // tone steps once per tally sample
  sine_tone_gen u_sine_tone_gen (
    .clk_m (clk_m),
    .rst_n (rst_n),
    .step  (pcm),
    .tone  (tone)
  );

  audio_output_stage u_audio_output_stage (
    .clk_m    (clk_m),
    .rst_n    (rst_n),
    .pdm_tick (pdm_tick),
    .src_sel  (src_sel),
    .vol      (vol),
    .tone     (tone),
    .dec      (dec_out),
    .mic_data (mic_data),
    .spk      (spk)
  );

endmodule

// ==== audio_top_asserts.sv ====
`include "audio_config.svh"

module audio_top_asserts (
  input logic clk_m,
  input logic rst_n,
  input logic pdm_tick,
  input logic pcm_valid,
  input logic dec_valid
);

  int fail_cnt = 0;  // failed assertion attempts, read by the testbench

  // tick is a single cycle and comes back one divider period later
  tick_width: assert property (@(posedge clk_m) disable iff (!rst_n)
    pdm_tick |=> !pdm_tick)
    else begin
      fail_cnt++;
      $error("pdm_tick wider than one cycle");
    end
  tick_period: assert property (@(posedge clk_m) disable iff (!rst_n)
    pdm_tick |-> ##(`MIC_CLK_DIV) pdm_tick)
    else begin
      fail_cnt++;
      $error("pdm_tick period broken");
    end

  // sample strobes are isolated pulses
  pcm_strobe: assert property (@(posedge clk_m) disable iff (!rst_n)
    pcm_valid |=> !pcm_valid)
    else begin
      fail_cnt++;
      $error("pcm.valid high two cycles in a row");
    end
  dec_strobe: assert property (@(posedge clk_m) disable iff (!rst_n)
    dec_valid |=> !dec_valid)
    else begin
      fail_cnt++;
      $error("dec_out.valid high two cycles in a row");
    end

  // from the second reset cycle on, every register has been cleared
  quiet_in_reset: assert property (@(posedge clk_m)
    (!rst_n ##1 !rst_n) |-> (!pdm_tick && !pcm_valid && !dec_valid))
    else begin
      fail_cnt++;
      $error("strobe high during reset");
    end

endmodule

bind audio_top audio_top_asserts u_audio_top_asserts (
  .clk_m     (clk_m),
  .rst_n     (rst_n),
  .pdm_tick  (pdm_tick),
  .pcm_valid (pcm.valid),
  .dec_valid (dec_out.valid)
);

// ==== tb_audio_top.sv ====
`include "audio_config.svh"

module tb_audio_top import audio_pkg::*; ();

  // time for one tally window in time units
  localparam longint WINDOW_TIME = `PDM_WINDOW * `MIC_CLK_DIV * 100;
  // windows per test for reset/clock, passthrough, decimation, silence, tone and dec
  localparam longint TEST_WINDOWS = 1 + 1 + 16 + 3 + 30;

  logic       clk_m;
  logic       rst_n;
  logic       mic_data;
  src_sel_e   src_sel;
  logic [2:0] vol;
  logic       mic_clk;
  logic       spk;
  dec_t       dec_out;

  int          pass_count = 0;
  int          fail_count = 0;
  logic [31:0] lcg_state = 32'hb08f69a9;
  bit          mic_lost = 1'b0;  // set once a lost mic_clk is reported
  int          dec_q [$];        // every dec_out sample since the last clear
  int          last_dec = 0;

  audio_top u_audio_top (
    .clk_m    (clk_m),
    .rst_n    (rst_n),
    .mic_data (mic_data),
    .src_sel  (src_sel),
    .vol      (vol),
    .mic_clk  (mic_clk),
    .spk      (spk),
    .dec_out  (dec_out)
  );

  initial begin
    clk_m = 1'b0;
    forever #50 clk_m = ~clk_m;
  end

  // log of every decimated sample
  always @(negedge clk_m) begin
    if (rst_n && dec_out.valid) begin
      dec_q.push_back(dec_out.data);
      last_dec = dec_out.data;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input integer expected, input integer actual);
    if (expected === actual) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_m);
    rst_n = 1'b0;
    repeat (3) @(negedge clk_m);
    rst_n = 1'b1;
  endtask

  // returns on the negedge of the first high cycle of mic_clk, which is the tick cycle
  task automatic wait_mic_rise(output bit ok);
    logic prev;
    int   n;
    prev = mic_clk;
    ok = 1'b0;
    for (n = 0; n < 2 * `MIC_CLK_DIV && !ok; n++) begin
      @(negedge clk_m);
      ok = mic_clk && !prev;
      prev = mic_clk;
    end
    if (!ok && !mic_lost) begin
      $display("mic_clk did not rise within two divider periods");
      fail_count++;
      mic_lost = 1'b1;
    end
  endtask

  // present a bit for one mic tick and return spk as updated by that tick
  task automatic tick_step(input logic bit_in, output logic spk_after);
    bit ok;
    wait_mic_rise(ok);
    mic_data = bit_in;
    @(negedge clk_m);
    spk_after = spk;
  endtask

  // drives ones on the first ones_k ticks and counts spk high over the window
  task automatic run_window(input int ones_k, output int spk_ones);
    int   i;
    logic s;
    spk_ones = 0;
    for (i = 0; i < `PDM_WINDOW; i++) begin
      tick_step(i < ones_k, s);
      spk_ones += s;
    end
    repeat (8) @(negedge clk_m);  // tally, FIR chain and level all settle well before next tick
  endtask

  // tally sample is ones minus half a window with the top end clipped
  function automatic int clamp_tally(input int ones);
    return (ones - 128 > 127) ? 127 : ones - 128;
  endfunction

  function automatic int binomial_out(input int h [4]);
    return (h[0] + 3 * h[1] + 3 * h[2] + h[3]) >>> 3;  // floor of the 1-3-3-1 average
  endfunction

  task automatic shift_history(inout int h [4], input int v);
    h[3] = h[2];
    h[2] = h[1];
    h[1] = h[0];
    h[0] = v;
  endtask

  task automatic test_reset_clock();
    int   errs0;
    int   p;
    int   len;
    int   high;
    logic prev;
    bit   ok;
    errs0 = fail_count;
    // rst_n is already low from time 0
    repeat (2) @(negedge clk_m);
    check_value("test_reset_clock mic_clk", 0, mic_clk);
    check_value("test_reset_clock spk", 0, spk);
    check_value("test_reset_clock dec_out.valid", 0, dec_out.valid);
    @(negedge clk_m);
    rst_n = 1'b1;
    wait_mic_rise(ok);
    for (p = 0; p < 8; p++) begin
      len = 0;
      high = 0;
      // count cycles from this rise up to the next one
      do begin
        high += mic_clk;
        len++;
        prev = mic_clk;
        @(negedge clk_m);
      end while (!(mic_clk && !prev) && len < 4 * `MIC_CLK_DIV);
      check_value("test_reset_clock period", `MIC_CLK_DIV, len);
      check_value("test_reset_clock high phase", `MIC_CLK_DIV / 2, high);
    end
    $display("test_reset_clock done, %0d errors", fail_count - errs0);
  endtask

  task automatic test_mic_passthrough();
    int          errs0;
    int          p;
    logic [31:0] r;
    logic        s;
    errs0 = fail_count;
    src_sel = SRC_MIC;
    vol = 3'd7;
    apply_reset();
    for (p = 0; p < 32; p++) begin
      r = lcg_next();
      tick_step(r[16], s);
      check_value("test_mic_passthrough", r[16], s);
    end
    $display("test_mic_passthrough done, %0d errors", fail_count - errs0);
  endtask

  task automatic test_decimation();
    int          errs0;
    int          w;
    int          k;
    int          n;
    int          ones;
    int          n1;
    int          n2;
    int          h1 [4];
    int          h2 [4];
    int          expected_q [$];
    logic [31:0] r;
    errs0 = fail_count;
    src_sel = SRC_SILENT;
    vol = 3'd7;
    h1 = '{default: 0};
    h2 = '{default: 0};
    n1 = 0;
    n2 = 0;
    apply_reset();
    dec_q.delete();
    for (w = 0; w < 16; w++) begin
      r = lcg_next();
      k = r % 257;
      run_window(k, ones);
      shift_history(h1, clamp_tally(k));
      n1++;
      if (n1 % 2 == 0) begin  // first stage keeps every second result
        shift_history(h2, binomial_out(h1));
        n2++;
        if (n2 % 2 == 0) expected_q.push_back(binomial_out(h2));
      end
    end
    n = 0;
    while (dec_q.size() < expected_q.size() && n < 4 * `MIC_CLK_DIV) begin
      @(negedge clk_m);
      n++;
    end
    if (dec_q.size() != expected_q.size()) begin
      $display("test_decimation saw %0d decimated samples instead of %0d",
               dec_q.size(), expected_q.size());
      fail_count++;
    end else begin
      foreach (expected_q[i]) check_value("test_decimation", expected_q[i], dec_q[i]);
    end
    $display("test_decimation done, %0d errors", fail_count - errs0);
  endtask

  task automatic test_silence_volume();
    int         errs0;
    int         v;
    int         ones;
    logic [2:0] vols [3] = '{3'd0, 3'd3, 3'd7};
    errs0 = fail_count;
    src_sel = SRC_SILENT;
    for (v = 0; v < 3; v++) begin
      vol = vols[v];
      apply_reset();
      run_window(0, ones);
      check_value("test_silence_volume", 128, ones);  // mid scale is half ones
    end
    $display("test_silence_volume done, %0d errors", fail_count - errs0);
  endtask

  task automatic test_tone_and_decimated();
    int errs0;
    int w;
    int entry;
    int ones;
    errs0 = fail_count;
    src_sel = SRC_TONE;
    vol = 3'd7;
    apply_reset();
    for (w = 0; w < 12; w++) begin
      if (w == 6) vol = 3'd5;  // lands between windows so the level follows before the next tick
      run_window(128, ones);
      // tone lags the tally by one window so window 0 plays the reset level
      entry = (w == 0) ? 0 : SINE_TABLE[(w - 1) % 64];
      check_value("test_tone_and_decimated tone", (entry >>> (7 - vol)) + 128, ones);
    end
    src_sel = SRC_DEC;
    vol = 3'd7;
    apply_reset();
    last_dec = 0;
    w = 0;
    while (last_dec != 127 && w < 16) begin
      run_window(`PDM_WINDOW, ones);
      w++;
    end
    if (last_dec != 127) begin
      $display("test_tone_and_decimated: dec_out never reached full scale");
      fail_count++;
    end else begin
      for (w = 0; w < 2; w++) begin
        run_window(`PDM_WINDOW, ones);
        check_value("test_tone_and_decimated dec", 255, ones);
      end
    end
    $display("test_tone_and_decimated done, %0d errors", fail_count - errs0);
  endtask

  initial begin
    rst_n = 1'b0;
    mic_data = 1'b0;
    src_sel = SRC_SILENT;
    vol = 3'd7;
    test_reset_clock();
    test_mic_passthrough();
    test_decimation();
    test_silence_volume();
    test_tone_and_decimated();
    if (u_audio_top.u_audio_top_asserts.fail_cnt != 0) begin
      $display("bound assertions failed %0d times", u_audio_top.u_audio_top_asserts.fail_cnt);
      fail_count++;
    end
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog at twice the nominal run length
  initial begin
    #(2 * TEST_WINDOWS * WINDOW_TIME);
    $display("timeout: the tests did not finish in the allowed simulation time");
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+.
audio_pkg.sv
mic_clock_gen.sv
pdm_tally.sv
fir_decimator.sv
sine_tone_gen.sv
audio_output_stage.sv
audio_top.sv
audio_top_asserts.sv
tb_audio_top.sv

// ==== Bender.yml ====
package:
  name: audio_path

export_include_dirs:
  - .

sources:
  - files:
      - audio_pkg.sv
      - mic_clock_gen.sv
      - pdm_tally.sv
      - fir_decimator.sv
      - sine_tone_gen.sv
      - audio_output_stage.sv
      - audio_top.sv
  - target: test
    files:
      - audio_top_asserts.sv
      - tb_audio_top.sv
